//--- rtl/accum_pkg.sv
package accum_pkg;

	// beat geometry
	localparam int lanes = 4;
	localparam int lane_width = 16;

	// psum buffer
	localparam int buf_rows = 256;
	localparam int addr_width = 8;

	// loop bounds and counters
	localparam int dim_width = 6;

	typedef logic [lane_width-1:0] lane_t;

	// one buffer row or one input beat
	typedef lane_t [lanes-1:0] psum_word_t;

	typedef logic [addr_width-1:0] psum_addr_t;

	// held stable while a run is in progress
	typedef struct packed {
		logic [dim_width-1:0] fkx;
		logic [dim_width-1:0] fky;
		logic [dim_width-1:0] x;
		logic [dim_width-1:0] y;
		logic [dim_width-1:0] ic;
		logic [dim_width-1:0] nc;
		logic [dim_width-1:0] batch;
	} accum_cfg_t;

	// per-beat tag, counter to rmw stage
	typedef struct packed {
		psum_addr_t addr;
		logic       first;
		logic       last;
	} loop_pos_t;

	// output plane width, stride one
	function automatic logic [dim_width-1:0] out_cols(accum_cfg_t cfg);
		return cfg.x - cfg.fkx + 1'b1;
	endfunction

	function automatic logic [dim_width-1:0] out_rows(accum_cfg_t cfg);
		return cfg.y - cfg.fky + 1'b1;
	endfunction

	// output channel groups, rounded up
	function automatic logic [dim_width-1:0] chan_groups(accum_cfg_t cfg);
		return dim_width'((cfg.nc + lanes - 1) / lanes);
	endfunction

endpackage

//--- rtl/loop_nest_counter.sv
module loop_nest_counter import accum_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  accum_cfg_t cfg,
	input  logic       start,
	input  logic       step,
	output loop_pos_t  pos
);

	logic [dim_width-1:0] yy;
	logic [dim_width-1:0] xx;
	logic [dim_width-1:0] kkx;
	logic [dim_width-1:0] kky;
	logic [dim_width-1:0] ii;
	logic [dim_width-1:0] nn;
	logic [dim_width-1:0] bb;

	logic [dim_width-1:0] ox;
	logic [dim_width-1:0] oy;
	logic [dim_width-1:0] n_groups;

	// one extra bit so the compare sees the overflow
	logic [dim_width:0] yy_inc;
	logic [dim_width:0] xx_inc;
	logic [dim_width:0] kkx_inc;
	logic [dim_width:0] kky_inc;
	logic [dim_width:0] ii_inc;
	logic [dim_width:0] nn_inc;
	logic [dim_width:0] bb_inc;

	logic y_wrap, x_wrap, kx_wrap, ky_wrap, i_wrap, n_wrap, b_wrap;
	logic adv_xx, adv_kkx, adv_kky, adv_ii, adv_nn, adv_bb;

	psum_addr_t grp_row;
	psum_addr_t col_row;
	psum_addr_t plane_row;

	assign ox = out_cols(cfg);
	assign oy = out_rows(cfg);
	assign n_groups = chan_groups(cfg);

	assign yy_inc = yy + 1'b1;
	assign xx_inc = xx + 1'b1;
	assign kkx_inc = kkx + 1'b1;
	assign kky_inc = kky + 1'b1;
	assign ii_inc = ii + (dim_width + 1)'(lanes);
	assign nn_inc = nn + (dim_width + 1)'(lanes);
	assign bb_inc = bb + 1'b1;

	assign y_wrap = yy_inc >= oy;
	assign x_wrap = xx_inc >= ox;
	assign kx_wrap = kkx_inc >= cfg.fkx;
	assign ky_wrap = kky_inc >= cfg.fky;
	assign i_wrap = ii_inc >= cfg.ic;
	assign n_wrap = nn_inc >= cfg.nc;
	assign b_wrap = bb_inc >= cfg.batch;

	// innermost-first carry chain
	assign adv_xx = y_wrap;
	assign adv_kkx = adv_xx && x_wrap;
	assign adv_kky = adv_kkx && kx_wrap;
	assign adv_ii = adv_kky && ky_wrap;
	assign adv_nn = adv_ii && i_wrap;
	assign adv_bb = adv_nn && n_wrap;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			yy <= '0;
			xx <= '0;
			kkx <= '0;
			kky <= '0;
			ii <= '0;
			nn <= '0;
			bb <= '0;
		end else if (start) begin
			yy <= '0;
			xx <= '0;
			kkx <= '0;
			kky <= '0;
			ii <= '0;
			nn <= '0;
			bb <= '0;
		end else if (step) begin
			yy <= y_wrap ? '0 : yy_inc[dim_width-1:0];
			if (adv_xx)
				xx <= x_wrap ? '0 : xx_inc[dim_width-1:0];
			if (adv_kkx)
				kkx <= kx_wrap ? '0 : kkx_inc[dim_width-1:0];
			if (adv_kky)
				kky <= ky_wrap ? '0 : kky_inc[dim_width-1:0];
			if (adv_ii)
				ii <= i_wrap ? '0 : ii_inc[dim_width-1:0];
			if (adv_nn)
				nn <= n_wrap ? '0 : nn_inc[dim_width-1:0];
			if (adv_bb)
				bb <= b_wrap ? '0 : bb_inc[dim_width-1:0];
		end
	end

	// row = ((bb * groups + nn/lanes) * ox + xx) * oy + yy
	assign grp_row = bb * n_groups + (nn >> $clog2(lanes));
	assign col_row = grp_row * ox + xx;
	assign plane_row = col_row * oy + yy;

	assign pos.addr = plane_row;
	assign pos.first = (ii == '0) && (kkx == '0) && (kky == '0);
	assign pos.last = adv_bb && b_wrap;

endmodule

//--- rtl/psum_buffer.sv
module psum_buffer import accum_pkg::*; (
	input  logic       clk,

	input  logic       rd_en,
	input  psum_addr_t rd_addr,
	output psum_word_t rd_data,

	input  logic       wr_en,
	input  psum_addr_t wr_addr,
	input  psum_word_t wr_data
);

	psum_word_t mem [buf_rows];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// same-cycle read of the write row returns old data
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

//--- rtl/psum_rmw.sv
module psum_rmw import accum_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,

	input  logic       in_valid,
	input  psum_word_t in_data,
	output logic       in_ready,

	input  loop_pos_t  pos,
	output logic       step,

	output logic       rd_en,
	output psum_addr_t rd_addr,
	input  psum_word_t rd_data,

	output logic       wr_en,
	output psum_addr_t wr_addr,
	output psum_word_t wr_data,

	output logic       accum_complete
);

	logic active;
	logic hazard;
	logic wr_valid;

	psum_word_t beat_q;
	loop_pos_t pos_q;

	// beat would read the row still being written
	assign hazard = wr_valid && (pos.addr == pos_q.addr);

	assign in_ready = active && !hazard;
	assign step = in_valid && in_ready;

	assign rd_en = step;
	assign rd_addr = pos.addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else if (start) begin
			active <= 1'b1;
		end else if (step && pos.last) begin
			active <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wr_valid <= 1'b0;
		else
			wr_valid <= step;
	end

	always_ff @(posedge clk) begin
		if (step) begin
			beat_q <= in_data;
			pos_q <= pos;
		end
	end

	assign wr_en = wr_valid;
	assign wr_addr = pos_q.addr;

	// lane adders, wrap on overflow
	always_comb begin
		for (int l = 0; l < lanes; l++) begin
			if (pos_q.first)
				wr_data[l] = beat_q[l];
			else
				wr_data[l] = beat_q[l] + rd_data[l];
		end
	end

	assign accum_complete = wr_valid && pos_q.last;

endmodule

//--- rtl/result_drain.sv
module result_drain import accum_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  accum_cfg_t cfg,
	input  logic       accum_complete,
	input  logic       start,
	output logic       drain_active,

	output logic       rd_en,
	output psum_addr_t rd_addr,
	input  psum_word_t rd_data,

	output logic       out_valid,
	output psum_word_t out_data,
	output psum_addr_t out_addr,
	input  logic       out_ready,

	output logic       done
);

	// wide enough to hold a full buffer count
	logic [addr_width:0] row_count;
	logic [addr_width:0] rd_ptr;

	logic rd_pending;
	logic skid_valid;
	logic out_stall;
	logic last_xfer;

	psum_addr_t rd_addr_q;
	psum_addr_t skid_addr;
	psum_addr_t last_row;
	psum_word_t skid_data;

	assign row_count = cfg.batch * chan_groups(cfg) * out_cols(cfg) * out_rows(cfg);
	assign last_row = row_count[addr_width-1:0] - 1'b1;

	assign out_stall = out_valid && !out_ready;
	assign rd_en = drain_active && (rd_ptr < row_count) && !out_stall;
	assign rd_addr = rd_ptr[addr_width-1:0];
	assign last_xfer = out_valid && out_ready && (out_addr == last_row);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drain_active <= 1'b0;
			done <= 1'b0;
			rd_ptr <= '0;
			rd_pending <= 1'b0;
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (start) begin
			drain_active <= 1'b0;
			done <= 1'b0;
			rd_ptr <= '0;
			rd_pending <= 1'b0;
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else begin
			if (accum_complete) begin
				drain_active <= 1'b1;
				rd_ptr <= '0;
			end else if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (last_xfer) begin
				drain_active <= 1'b0;
				done <= 1'b1;
			end
			rd_pending <= rd_en;
			// skid holds a read that returns during a stall
			if (!out_stall) begin
				out_valid <= skid_valid || rd_pending;
				skid_valid <= 1'b0;
			end else begin
				skid_valid <= skid_valid || rd_pending;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			rd_addr_q <= rd_addr;
		if (!out_stall) begin
			if (skid_valid) begin
				out_data <= skid_data;
				out_addr <= skid_addr;
			end else if (rd_pending) begin
				out_data <= rd_data;
				out_addr <= rd_addr_q;
			end
		end
		if (rd_pending && out_stall) begin
			skid_data <= rd_data;
			skid_addr <= rd_addr_q;
		end
	end

endmodule

//--- rtl/accum_top.sv
module accum_top import accum_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,

	input  accum_cfg_t cfg,
	input  logic       start,

	input  logic       in_valid,
	input  psum_word_t in_data,
	output logic       in_ready,

	output logic       out_valid,
	output psum_word_t out_data,
	output psum_addr_t out_addr,
	input  logic       out_ready,

	output logic       done
);

	loop_pos_t pos;
	logic step;

	logic rmw_rd_en;
	psum_addr_t rmw_rd_addr;
	logic drain_rd_en;
	psum_addr_t drain_rd_addr;
	logic buf_rd_en;
	psum_addr_t buf_rd_addr;
	psum_word_t buf_rd_data;

	logic wr_en;
	psum_addr_t wr_addr;
	psum_word_t wr_data;

	logic accum_complete;
	logic drain_active;

	loop_nest_counter loop_nest_counter_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.cfg   (cfg),
		.start (start),
		.step  (step),
		.pos   (pos)
	);

	psum_rmw psum_rmw_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.start          (start),
		.in_valid       (in_valid),
		.in_data        (in_data),
		.in_ready       (in_ready),
		.pos            (pos),
		.step           (step),
		.rd_en          (rmw_rd_en),
		.rd_addr        (rmw_rd_addr),
		.rd_data        (buf_rd_data),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.accum_complete (accum_complete)
	);

	// drain owns the read port once accumulation is finished
	assign buf_rd_en = drain_active ? drain_rd_en : rmw_rd_en;
	assign buf_rd_addr = drain_active ? drain_rd_addr : rmw_rd_addr;

	psum_buffer psum_buffer_inst (
		.clk     (clk),
		.rd_en   (buf_rd_en),
		.rd_addr (buf_rd_addr),
		.rd_data (buf_rd_data),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	result_drain result_drain_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg            (cfg),
		.accum_complete (accum_complete),
		.start          (start),
		.drain_active   (drain_active),
		.rd_en          (drain_rd_en),
		.rd_addr        (drain_rd_addr),
		.rd_data        (buf_rd_data),
		.out_valid      (out_valid),
		.out_data       (out_data),
		.out_addr       (out_addr),
		.out_ready      (out_ready),
		.done           (done)
	);

endmodule

//--- testbench/accum_assertions.sv
module accum_assertions import accum_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input accum_cfg_t cfg,
	input logic       start,
	input logic       in_valid,
	input psum_word_t in_data,
	input logic       in_ready,
	input logic       out_valid,
	input psum_word_t out_data,
	input psum_addr_t out_addr,
	input logic       out_ready,
	input logic       done
);

	psum_word_t shadow [buf_rows];
	psum_word_t expect_word;
	psum_word_t prev_data;
	psum_addr_t prev_out_addr;
	int ox, oy, i_grps, n_grps, rows, beats;
	int beat_idx, xfer_idx, m_addr, prev_addr;
	logic m_first, m_last, running, step;

	// latest failure, picked up by the testbench
	int fail_count = 0;
	logic [63:0] fail_exp;
	logic [63:0] fail_act;

	function automatic psum_word_t add_lanes(input psum_word_t a, input psum_word_t b);
		psum_word_t s;
		for (int l = 0; l < lanes; l++)
			s[l] = a[l] + b[l];
		return s;
	endfunction

	task automatic note_fail(input logic [63:0] exp, input logic [63:0] act);
		fail_count++;
		fail_exp = exp;
		fail_act = act;
	endtask

	assign ox = int'(cfg.x) - int'(cfg.fkx) + 1;
	assign oy = int'(cfg.y) - int'(cfg.fky) + 1;
	assign i_grps = (int'(cfg.ic) + lanes - 1) / lanes;
	assign n_grps = (int'(cfg.nc) + lanes - 1) / lanes;
	assign rows = int'(cfg.batch) * n_grps * ox * oy;
	assign beats = rows * int'(cfg.fkx) * int'(cfg.fky) * i_grps;
	assign step = in_valid && in_ready;
	assign expect_word = shadow[out_addr];

	// beat index split into loop positions, yy innermost
	always_comb begin
		int k, yy, xx, kx, ky, ig, ng;
		k = beat_idx;
		yy = k % oy;
		k = k / oy;
		xx = k % ox;
		k = k / ox;
		kx = k % int'(cfg.fkx);
		k = k / int'(cfg.fkx);
		ky = k % int'(cfg.fky);
		k = k / int'(cfg.fky);
		ig = k % i_grps;
		k = k / i_grps;
		ng = k % n_grps;
		k = k / n_grps;
		m_addr = ((k * n_grps + ng) * ox + xx) * oy + yy;
		m_first = (ig == 0) && (kx == 0) && (ky == 0);
		m_last = (beat_idx == beats - 1);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_idx <= 0;
			xfer_idx <= 0;
			running <= 1'b0;
		end else if (start) begin
			beat_idx <= 0;
			xfer_idx <= 0;
			running <= 1'b1;
		end else begin
			if (step) begin
				beat_idx <= beat_idx + 1;
				prev_addr <= m_addr;
				if (m_first)
					shadow[psum_addr_t'(m_addr)] <= in_data;
				else
					shadow[psum_addr_t'(m_addr)] <= add_lanes(shadow[psum_addr_t'(m_addr)], in_data);
				if (m_last)
					running <= 1'b0;
			end
			if (out_valid && out_ready)
				xfer_idx <= xfer_idx + 1;
		end
	end

	always_ff @(posedge clk) begin
		prev_data <= out_data;
		prev_out_addr <= out_addr;
	end

	a_idle: assert property (@(posedge clk)
		!rst_n |=> !in_ready && !out_valid && !done)
		else begin
			$error("in_ready, out_valid or done high during reset");
			note_fail(64'd0, 64'($sampled({in_ready, out_valid, done})));
		end

	a_start: assert property (@(posedge clk) disable iff (!rst_n)
		start |=> in_ready && !done && !out_valid)
		else begin
			$error("start did not open the input or clear done");
			note_fail(64'b100, 64'($sampled({in_ready, done, out_valid})));
		end

	// same row as the beat just taken means one stall cycle
	a_hazard: assert property (@(posedge clk) disable iff (!rst_n)
		step && !m_last |=> in_ready == (m_addr != prev_addr))
		else begin
			$error("in_ready does not follow the row hazard");
			note_fail(64'($sampled(m_addr != prev_addr)), 64'($sampled(in_ready)));
		end

	a_stall_one: assert property (@(posedge clk) disable iff (!rst_n)
		running && !in_ready |=> in_ready)
		else begin
			$error("input stall longer than one cycle");
			note_fail(64'd1, 64'($sampled(in_ready)));
		end

	a_data: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_data == expect_word)
		else begin
			$error("drained row differs from the accumulated sum");
			note_fail($sampled(expect_word), $sampled(out_data));
		end

	a_order: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_addr == psum_addr_t'(xfer_idx) && xfer_idx < rows)
		else begin
			$error("drained row out of order or beyond the used rows");
			note_fail(64'($sampled(xfer_idx)), 64'($sampled(out_addr)));
		end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && out_data == prev_data
		&& out_addr == prev_out_addr)
		else begin
			$error("output row changed while stalled");
			note_fail($sampled(prev_data), $sampled(out_data));
		end

	a_done: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> xfer_idx == rows && $past(out_valid && out_ready))
		else begin
			$error("done without the full row count or not after the last row");
			note_fail(64'($sampled(rows)), 64'($sampled(xfer_idx)));
		end

endmodule

bind accum_top accum_assertions accum_assertions_inst (.*);

//--- testbench/accum_tb.sv
module accum_tb import accum_pkg::*; ();

	logic       clk;
	logic       rst_n;
	accum_cfg_t cfg;
	logic       start;
	logic       in_valid;
	psum_word_t in_data;
	logic       in_ready;
	logic       out_valid;
	psum_word_t out_data;
	psum_addr_t out_addr;
	logic       out_ready;
	logic       done;

	logic [31:0] data_state;
	logic [31:0] gap_state;
	logic        gaps_on;
	int          tests_run;
	int          tests_failed;

	accum_top accum_top_inst (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	function automatic accum_cfg_t cfg_for(input int idx);
		accum_cfg_t c;
		case (idx)
			0: c = '{fkx: 6'd1, fky: 6'd1, x: 6'd4, y: 6'd3, ic: 6'd4, nc: 6'd8, batch: 6'd2};
			1: c = '{fkx: 6'd3, fky: 6'd3, x: 6'd6, y: 6'd5, ic: 6'd8, nc: 6'd4, batch: 6'd1};
			// 1x1 output plane, every beat hits the row just written
			2: c = '{fkx: 6'd2, fky: 6'd3, x: 6'd2, y: 6'd3, ic: 6'd8, nc: 6'd8, batch: 6'd2};
			3: c = '{fkx: 6'd2, fky: 6'd2, x: 6'd9, y: 6'd7, ic: 6'd4, nc: 6'd8, batch: 6'd2};
			4: c = '{fkx: 6'd1, fky: 6'd1, x: 6'd3, y: 6'd3, ic: 6'd4, nc: 6'd4, batch: 6'd1};
			default: c = '{fkx: 6'd1, fky: 6'd2, x: 6'd5, y: 6'd4, ic: 6'd12, nc: 6'd4, batch: 6'd3};
		endcase
		return c;
	endfunction

	function automatic int rows_of(input accum_cfg_t c);
		return int'(c.batch) * ((int'(c.nc) + lanes - 1) / lanes)
			* (int'(c.x) - int'(c.fkx) + 1) * (int'(c.y) - int'(c.fky) + 1);
	endfunction

	function automatic int beats_of(input accum_cfg_t c);
		return rows_of(c) * int'(c.fkx) * int'(c.fky) * ((int'(c.ic) + lanes - 1) / lanes);
	endfunction

	// random ready gaps when enabled, otherwise always ready
	always @(posedge clk) begin
		#2;
		gap_state = xorshift(gap_state);
		out_ready = !gaps_on || gap_state[4];
	end

	task automatic send_beat();
		logic [63:0] word;
		logic taken;
		data_state = xorshift(data_state);
		word[63:32] = data_state;
		data_state = xorshift(data_state);
		word[31:0] = data_state;
		in_data = word;
		in_valid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = in_ready;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
	endtask

	task automatic run_config(input accum_cfg_t c);
		int n;
		n = beats_of(c);
		cfg = c;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		for (int b = 0; b < n; b++)
			send_beat();
		while (!done)
			@(negedge clk);
		// let the checks on the done edge settle
		repeat (2) @(posedge clk);
		#2;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (accum_top_inst.accum_assertions_inst.fail_count != errs_before) begin
			tests_failed++;
			$display("[FAIL] %s expected %h actual %h", name,
				accum_top_inst.accum_assertions_inst.fail_exp,
				accum_top_inst.accum_assertions_inst.fail_act);
		end else begin
			$display("[PASS] %s", name);
		end
	endtask

	task automatic run_test(input string name, input int idx);
		int errs;
		errs = accum_top_inst.accum_assertions_inst.fail_count;
		run_config(cfg_for(idx));
		finish_test(name, errs);
	endtask

	initial begin
		int limit;
		limit = 200;
		for (int i = 0; i < 6; i++)
			limit += (beats_of(cfg_for(i)) + rows_of(cfg_for(i))) * 4;
		repeat (limit) @(posedge clk);
		$display("timeout: tests still running after %0d cycles", limit);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int errs;
		clk = 1'b0;
		rst_n = 1'b0;
		cfg = cfg_for(0);
		start = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b1;
		gaps_on = 1'b0;
		data_state = 32'hb283_6762;
		gap_state = xorshift(32'hb283_6762);
		tests_run = 0;
		tests_failed = 0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		run_test("single_pass", 0);
		run_test("accumulation", 1);
		run_test("hazard_stall", 2);
		gaps_on = 1'b1;
		run_test("out_backpressure", 3);
		// reset while idle, then two starts without a reset between
		errs = accum_top_inst.accum_assertions_inst.fail_count;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		run_config(cfg_for(4));
		run_config(cfg_for(5));
		finish_test("reset_restart", errs);
		$display("%0d tests run, %0d failed, %0d assertion failures", tests_run, tests_failed,
			accum_top_inst.accum_assertions_inst.fail_count);
		if (tests_failed == 0 && accum_top_inst.accum_assertions_inst.fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- all.f
rtl/accum_pkg.sv
rtl/loop_nest_counter.sv
rtl/psum_buffer.sv
rtl/psum_rmw.sv
rtl/result_drain.sv
rtl/accum_top.sv
testbench/accum_assertions.sv
testbench/accum_tb.sv
